// File: flist.f
source/dispatch_pkg.sv
source/instr_decoder.sv
source/scalar_status_table.sv
source/matrix_status_table.sv
source/issue_control.sv
source/dispatch_top.sv
test/dispatch_assertions.sv
test/tb_dispatch.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and decide on the log
rm -f sim.log build.log
verilator --binary --assert --timing --top-module tb_dispatch -f flist.f \
    -o sim_dispatch > build.log 2>&1 &&
    ./obj_dir/sim_dispatch > sim.log 2>&1
grep -q "NO ERRORS" sim.log && echo "simulation passed" ||
    { echo "simulation failed, see sim.log and build.log"; exit 1; }

// File: test/tb_dispatch.sv
module tb_dispatch;
    timeunit 1ns;
    timeprecision 100ps;

    import dispatch_pkg::*;

    localparam int RUN_CYCLES = 2000;
    localparam int TIMEOUT    = 2100;

    logic              CLK;
    logic              nRST;
    logic              instr_valid;
    logic [WORD_W-1:0] instr;
    logic [FU_N-1:0]   unit_busy;
    scalar_wb_t        s_wb;
    matrix_wb_t        m_wb;
    logic              branch_miss;
    logic              issue_valid;
    issue_t            issue;
    logic              freeze;
    logic              halted;

    // reference state of the dispatch stage
    logic [SREG_N-1:0] sbusy;
    stag_e             stag [SREG_N];
    logic [MREG_N-1:0] mbusy;
    mtag_e             mtag [MREG_N];
    logic              halt_ref;
    logic              exp_valid;
    issue_t            exp_issue;
    logic              hold_instr;
    logic [31:0]       seed;
    int                cycles;
    int                stim_cycle;

    dispatch_top u_dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .instr_valid (instr_valid),
        .instr       (instr),
        .unit_busy   (unit_busy),
        .s_wb        (s_wb),
        .m_wb        (m_wb),
        .branch_miss (branch_miss),
        .issue_valid (issue_valid),
        .issue       (issue),
        .freeze      (freeze),
        .halted      (halted)
    );

    always #5 CLK = ~CLK;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // opcode table of the instruction set, written out per opcode
    function automatic decoded_t decode_ref(input logic [WORD_W-1:0] w);
        decoded_t d;
        d = '0;
        d.op = opcode_e'(w[3:0]);
        case (w[3:0])
            4'd1, 4'd2, 4'd3, 4'd6, 4'd7: begin
                d.s_write = 1'b1;
                d.s_rd = w[8:4];
            end
            default: d.s_write = 1'b0;
        endcase
        case (w[3:0])
            4'd1: {d.unit, d.s_tag, d.s_rs1, d.s_rs2} = {FU_ALU, STAG_ALU, w[13:9], w[18:14]};
            4'd2: {d.unit, d.s_tag, d.s_rs1} = {FU_ALU, STAG_ALU, w[13:9]};
            4'd3: {d.unit, d.s_tag, d.s_rs1} = {FU_SLS, STAG_LOAD, w[13:9]};
            4'd4: {d.unit, d.s_rs1, d.s_rs2} = {FU_SLS, w[13:9], w[18:14]};
            4'd5: {d.unit, d.s_rs1, d.s_rs2} = {FU_BR, w[13:9], w[18:14]};
            4'd6: {d.unit, d.s_tag} = {FU_BR, STAG_JUMP};
            4'd7: {d.unit, d.s_tag, d.s_rs1} = {FU_BR, STAG_JUMP, w[13:9]};
            4'd8: {d.unit, d.m_write, d.m_tag, d.s_rs1, d.md} =
                {FU_MLS, 1'b1, MTAG_LOAD, w[13:9], w[9:4]};
            4'd9: {d.unit, d.s_rs1, d.md} = {FU_MLS, w[13:9], w[9:4]};
            4'd10: {d.unit, d.m_write, d.m_tag, d.md, d.ms1, d.ms2, d.ms3} =
                {FU_GEMM, 1'b1, MTAG_GEMM, w[9:4], w[15:10], w[21:16], w[27:22]};
            4'd11: d.unit = FU_NONE;
            default: d.op = NOP;
        endcase
        return d;
    endfunction

    function automatic stag_e s_look(input logic [SREG_W-1:0] i);
        if (sbusy[i] && !(s_wb.en && s_wb.idx == i)) return stag[i];
        return STAG_NONE;
    endfunction

    function automatic mtag_e m_look(input logic used, input logic [MREG_W-1:0] i);
        if (used && mbusy[i] && !(m_wb.en && m_wb.idx == i)) return mtag[i];
        return MTAG_NONE;
    endfunction

    task automatic report_fail(input string what, input string exp_s, input string act_s);
        $display("mismatch %s cycle %0d expected %s actual %s", what, stim_cycle, exp_s, act_s);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_issue(input string what, input issue_t exp, input issue_t act);
        if (act !== exp) report_fail(what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) report_fail(what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_idle();
        if ({issue_valid, freeze, halted} !== 3'b000) begin
            report_fail("idle after reset", "000", $sformatf("%b%b%b", issue_valid, freeze, halted));
        end
    endtask

    // compares the outputs of this cycle, then advances the model past the next edge
    task automatic check_and_step();
        decoded_t   d;
        logic       accept;
        logic       hazard;
        logic       busy_hit;
        logic       e_fire;
        logic       e_halted;
        logic [2:0] ui;
        d = decode_ref(instr);
        ui = 3'(d.unit) - 3'd1;
        busy_hit = (d.unit != FU_NONE) && unit_busy[ui];
        accept = instr_valid && !halt_ref && !branch_miss;
        hazard = (d.s_write && sbusy[d.s_rd]) || (d.m_write && mbusy[d.md]) || busy_hit;
        e_fire = accept && !hazard && (d.unit != FU_NONE);
        e_halted = !branch_miss && (halt_ref || (accept && d.op == HALT));
        check_flag("issue_valid", exp_valid, issue_valid);
        if (exp_valid) check_issue("issue", exp_issue, issue);
        check_flag("freeze", accept && hazard, freeze);
        check_flag("halted", e_halted, halted);
        if (e_fire) begin
            exp_issue = '{d.op, d.unit, d.s_rd, d.s_rs1, d.s_rs2, d.md, d.ms1, d.ms2, d.ms3,
                s_look(d.s_rs1), s_look(d.s_rs2),
                m_look(d.op == GEMM || d.op == MSTORE, (d.op == MSTORE) ? d.md : d.ms1),
                m_look(d.op == GEMM, d.ms2), m_look(d.op == GEMM, d.ms3)};
        end
        if (s_wb.en) sbusy[s_wb.idx] = 1'b0;
        if (m_wb.en) mbusy[m_wb.idx] = 1'b0;
        if (e_fire && d.s_write && d.s_rd != '0) begin
            sbusy[d.s_rd] = 1'b1;
            stag[d.s_rd] = d.s_tag;
        end
        if (e_fire && d.m_write) begin
            mbusy[d.md] = 1'b1;
            mtag[d.md] = d.m_tag;
        end
        halt_ref = e_halted;
        exp_valid = e_fire;
        hold_instr = accept && hazard;
    endtask

    // register fields stay in 0..7 so that hazards and bypasses come up often
    task automatic drive_random();
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  op;
        a = lcg_next();
        b = lcg_next();
        op = a[19:16];
        if (!hold_instr) begin
            instr_valid <= (a[31:24] < 8'd205);
            if (op < 4'd10) begin
                instr <= {13'b0, 2'b0, b[18:16], 2'b0, b[21:19], 2'b0, b[24:22], op};
            end else begin
                instr <= {4'b0, 3'b0, b[18:16], 3'b0, b[21:19], 3'b0, b[24:22], 3'b0, b[27:25], op};
            end
        end
        a = lcg_next();
        unit_busy <= {a[31:24] < 8'd38, a[23:16] < 8'd38, a[15:8] < 8'd38,
            b[31:28] < 4'd2, b[15:12] < 4'd3};
        b = lcg_next();
        s_wb <= '{b[31:30] == 2'b00, {2'b0, b[29:27]}};
        // a matrix load can name md 32..39 through the bit it shares with rs1
        m_wb <= '{b[26:25] == 2'b00, {b[13], 2'b0, b[24:22]}};
        branch_miss <= (b[21:14] < 8'd8);
    endtask

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        unit_busy = '0;
        s_wb = '0;
        m_wb = '0;
        branch_miss = 1'b0;
        seed = 32'd66;
        cycles = 0;
        stim_cycle = 0;
        sbusy = '0;
        mbusy = '0;
        halt_ref = 1'b0;
        exp_valid = 1'b0;
        exp_issue = '0;
        hold_instr = 1'b0;
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_idle();
        for (stim_cycle = 1; stim_cycle <= RUN_CYCLES; stim_cycle++) begin
            @(posedge CLK);
            drive_random();
            @(negedge CLK);
            check_and_step();
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: test/dispatch_assertions.sv
module dispatch_assertions (
    input logic              CLK,
    input logic              nRST,
    input logic              fire,
    input logic              freeze,
    input logic              branch_miss,
    input logic              issue_valid,
    input dispatch_pkg::fu_e unit
);
    timeunit 1ns;
    timeprecision 100ps;

    import dispatch_pkg::*;

    // a stalled word must never reach the issue register
    a_freeze_fire: assert property (@(posedge CLK) disable iff (!nRST)
        !(freeze && fire))
        else $error("freeze and fire are high in the same cycle");

    // the miss cycle blocks dispatch, so the next cycle has nothing issued
    a_miss_blocks: assert property (@(posedge CLK) disable iff (!nRST)
        branch_miss |=> !issue_valid)
        else $error("issue_valid follows a branch miss cycle");

    a_unit_real: assert property (@(posedge CLK) disable iff (!nRST)
        issue_valid |-> (unit != FU_NONE))
        else $error("an operation was issued without a functional unit");

endmodule

bind issue_control dispatch_assertions u_assertions (
    .CLK         (CLK),
    .nRST        (nRST),
    .fire        (fire),
    .freeze      (freeze),
    .branch_miss (branch_miss),
    .issue_valid (issue_valid),
    .unit        (issue.unit)
);

// File: source/dispatch_top.sv
module dispatch_top (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            instr_valid,
    input  logic [dispatch_pkg::WORD_W-1:0] instr,
    input  logic [dispatch_pkg::FU_N-1:0]   unit_busy,
    input  dispatch_pkg::scalar_wb_t        s_wb,
    input  dispatch_pkg::matrix_wb_t        m_wb,
    input  logic                            branch_miss,
    output logic                            issue_valid,
    output dispatch_pkg::issue_t            issue,
    output logic                            freeze,
    output logic                            halted
);
    import dispatch_pkg::*;

    decoded_t    dec;
    scalar_src_t s_src;
    matrix_src_t m_src;
    logic        fire;

    instr_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    // both tables look up in parallel and are written by the same fire
    scalar_status_table u_scalar_table (
        .CLK  (CLK),
        .nRST (nRST),
        .dec  (dec),
        .fire (fire),
        .s_wb (s_wb),
        .src  (s_src)
    );

    matrix_status_table u_matrix_table (
        .CLK  (CLK),
        .nRST (nRST),
        .dec  (dec),
        .fire (fire),
        .m_wb (m_wb),
        .src  (m_src)
    );

    issue_control u_issue (
        .CLK         (CLK),
        .nRST        (nRST),
        .instr_valid (instr_valid),
        .dec         (dec),
        .s_src       (s_src),
        .m_src       (m_src),
        .unit_busy   (unit_busy),
        .branch_miss (branch_miss),
        .fire        (fire),
        .issue_valid (issue_valid),
        .issue       (issue),
        .freeze      (freeze),
        .halted      (halted)
    );

endmodule

// File: source/issue_control.sv
module issue_control (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          instr_valid,
    input  dispatch_pkg::decoded_t        dec,
    input  dispatch_pkg::scalar_src_t     s_src,
    input  dispatch_pkg::matrix_src_t     m_src,
    input  logic [dispatch_pkg::FU_N-1:0] unit_busy,
    input  logic                          branch_miss,
    output logic                          fire,
    output logic                          issue_valid,
    output dispatch_pkg::issue_t          issue,
    output logic                          freeze,
    output logic                          halted
);
    import dispatch_pkg::*;

    logic       halt_q;
    logic       accept;
    logic       hazard;
    logic       busy_hit;
    logic [2:0] busy_idx;

    // the latched halt blocks new words, and a branch miss blocks the current one
    assign accept = instr_valid && !halt_q && !branch_miss;

    // unit_busy is indexed from the first real unit
    assign busy_idx = dec.unit - 3'd1;

    always_comb begin
        busy_hit = 1'b0;
        if (dec.unit != FU_NONE) begin
            busy_hit = unit_busy[busy_idx];
        end
    end

    assign hazard = s_src.waw || m_src.waw || busy_hit;
    assign freeze = accept && hazard;
    assign fire   = accept && !hazard && (dec.unit != FU_NONE);

    // halted rises with the HALT itself and drops during a branch miss
    assign halted = !branch_miss && (halt_q || (accept && (dec.op == HALT)));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            halt_q      <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            halt_q      <= halted;
            issue_valid <= fire;
        end
    end

    // the payload only matters while issue_valid is high
    always_ff @(posedge CLK) begin
        if (fire) begin
            issue.op    <= dec.op;
            issue.unit  <= dec.unit;
            issue.s_rd  <= dec.s_rd;
            issue.s_rs1 <= dec.s_rs1;
            issue.s_rs2 <= dec.s_rs2;
            issue.md    <= dec.md;
            issue.ms1   <= dec.ms1;
            issue.ms2   <= dec.ms2;
            issue.ms3   <= dec.ms3;
            issue.t1    <= s_src.t1;
            issue.t2    <= s_src.t2;
            issue.g1    <= m_src.g1;
            issue.g2    <= m_src.g2;
            issue.g3    <= m_src.g3;
        end
    end

endmodule

// File: source/matrix_status_table.sv
module matrix_status_table (
    input  logic                      CLK,
    input  logic                      nRST,
    input  dispatch_pkg::decoded_t    dec,
    input  logic                      fire,
    input  dispatch_pkg::matrix_wb_t  m_wb,
    output dispatch_pkg::matrix_src_t src
);
    import dispatch_pkg::*;

    logic [MREG_N-1:0] busy;
    mtag_e             tag [MREG_N];
    logic              set_en;
    logic              is_gemm;
    logic              is_mstore;
    logic [MREG_W-1:0] src1_idx;

    assign set_en    = fire && dec.m_write;
    assign is_gemm   = (dec.op == GEMM);
    assign is_mstore = (dec.op == MSTORE);

    // matrix register 0 is a real scratchpad slot, so unused sources are masked by opcode
    assign src1_idx = is_mstore ? dec.md : dec.ms1;

    function automatic mtag_e lookup(input logic used, input logic [MREG_W-1:0] idx);
        mtag_e result;
        result = MTAG_NONE;
        if (used && busy[idx] && !(m_wb.en && (m_wb.idx == idx))) begin
            result = tag[idx];
        end
        return result;
    endfunction

    always_comb begin
        src.waw = dec.m_write && busy[dec.md];
        src.g1  = lookup(is_gemm || is_mstore, src1_idx);
        src.g2  = lookup(is_gemm, dec.ms2);
        src.g3  = lookup(is_gemm, dec.ms3);
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
        end else begin
            if (m_wb.en) begin
                busy[m_wb.idx] <= 1'b0;
            end
            // set comes last so it overrides a writeback to the same slot
            if (set_en) begin
                busy[dec.md] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (set_en) begin
            tag[dec.md] <= dec.m_tag;
        end
    end

endmodule

// File: source/scalar_status_table.sv
module scalar_status_table (
    input  logic                      CLK,
    input  logic                      nRST,
    input  dispatch_pkg::decoded_t    dec,
    input  logic                      fire,
    input  dispatch_pkg::scalar_wb_t  s_wb,
    output dispatch_pkg::scalar_src_t src
);
    import dispatch_pkg::*;

    logic [SREG_N-1:0] busy;
    stag_e             tag [SREG_N];
    logic              set_en;

    // register 0 is hardwired, so it never becomes pending
    assign set_en = fire && dec.s_write && (dec.s_rd != '0);

    // a writeback in this cycle already frees the register for readers
    function automatic stag_e lookup(input logic [SREG_W-1:0] idx);
        stag_e result;
        result = STAG_NONE;
        if (busy[idx] && !(s_wb.en && (s_wb.idx == idx))) begin
            result = tag[idx];
        end
        return result;
    endfunction

    always_comb begin
        src.waw = dec.s_write && busy[dec.s_rd];
        src.t1  = lookup(dec.s_rs1);
        src.t2  = lookup(dec.s_rs2);
    end

    // a set after the clear lets a new producer win over a same-cycle writeback
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
        end else begin
            if (s_wb.en) begin
                busy[s_wb.idx] <= 1'b0;
            end
            if (set_en) begin
                busy[dec.s_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (set_en) begin
            tag[dec.s_rd] <= dec.s_tag;
        end
    end

endmodule

// File: source/instr_decoder.sv
module instr_decoder (
    input  logic [dispatch_pkg::WORD_W-1:0] instr,
    output dispatch_pkg::decoded_t          dec
);
    import dispatch_pkg::*;

    opcode_e           opc;
    logic [SREG_W-1:0] f_rd;
    logic [SREG_W-1:0] f_rs1;
    logic [SREG_W-1:0] f_rs2;
    logic [MREG_W-1:0] f_md;
    logic [MREG_W-1:0] f_ms1;
    logic [MREG_W-1:0] f_ms2;
    logic [MREG_W-1:0] f_ms3;

    assign opc   = opcode_e'(instr[OP_LSB +: OP_W]);
    assign f_rd  = instr[RD_LSB +: SREG_W];
    assign f_rs1 = instr[RS1_LSB +: SREG_W];
    assign f_rs2 = instr[RS2_LSB +: SREG_W];
    assign f_md  = instr[MD_LSB +: MREG_W];
    assign f_ms1 = instr[MS1_LSB +: MREG_W];
    assign f_ms2 = instr[MS2_LSB +: MREG_W];
    assign f_ms3 = instr[MS3_LSB +: MREG_W];

    // fields that an opcode does not use stay zero so the tables see no false match
    always_comb begin
        dec    = '0;
        dec.op = opc;
        case (opc)
            ALU, ALUI: begin
                dec.unit    = FU_ALU;
                dec.s_write = 1'b1;
                dec.s_rd    = f_rd;
                dec.s_rs1   = f_rs1;
                dec.s_rs2   = (opc == ALU) ? f_rs2 : '0;
                dec.s_tag   = STAG_ALU;
            end
            LOAD: begin
                dec.unit    = FU_SLS;
                dec.s_write = 1'b1;
                dec.s_rd    = f_rd;
                dec.s_rs1   = f_rs1;
                dec.s_tag   = STAG_LOAD;
            end
            STORE, BRANCH: begin
                dec.unit  = (opc == STORE) ? FU_SLS : FU_BR;
                dec.s_rs1 = f_rs1;
                dec.s_rs2 = f_rs2;
            end
            JAL, JALR: begin
                dec.unit    = FU_BR;
                dec.s_write = 1'b1;
                dec.s_rd    = f_rd;
                dec.s_rs1   = (opc == JALR) ? f_rs1 : '0;
                dec.s_tag   = STAG_JUMP;
            end
            MLOAD, MSTORE: begin
                // the scalar rs1 holds the memory address for both
                dec.unit    = FU_MLS;
                dec.s_rs1   = f_rs1;
                dec.md      = f_md;
                dec.m_write = (opc == MLOAD);
                dec.m_tag   = (opc == MLOAD) ? MTAG_LOAD : MTAG_NONE;
            end
            GEMM: begin
                dec.unit    = FU_GEMM;
                dec.m_write = 1'b1;
                dec.md      = f_md;
                dec.ms1     = f_ms1;
                dec.ms2     = f_ms2;
                dec.ms3     = f_ms3;
                dec.m_tag   = MTAG_GEMM;
            end
            HALT: begin
                dec.unit = FU_NONE;
            end
            default: begin
                dec.op = NOP;
            end
        endcase
    end

endmodule

// File: source/dispatch_pkg.sv
package dispatch_pkg;

    // instruction word and register file sizes
    localparam int WORD_W = 32;
    localparam int SREG_N = 32;
    localparam int SREG_W = 5;
    localparam int MREG_N = 64;
    localparam int MREG_W = 6;
    localparam int TAG_W  = 2;
    localparam int FU_N   = 5;

    // field positions of the simplified instruction layout
    localparam int OP_LSB  = 0;
    localparam int OP_W    = 4;
    localparam int RD_LSB  = 4;
    localparam int RS1_LSB = 9;
    localparam int RS2_LSB = 14;
    localparam int MD_LSB  = 4;
    localparam int MS1_LSB = 10;
    localparam int MS2_LSB = 16;
    localparam int MS3_LSB = 22;

    typedef enum logic [OP_W-1:0] {
        NOP    = 4'd0,
        ALU    = 4'd1,
        ALUI   = 4'd2,
        LOAD   = 4'd3,
        STORE  = 4'd4,
        BRANCH = 4'd5,
        JAL    = 4'd6,
        JALR   = 4'd7,
        MLOAD  = 4'd8,
        MSTORE = 4'd9,
        GEMM   = 4'd10,
        HALT   = 4'd11
    } opcode_e;

    // unit_busy bit n belongs to unit value n+1
    typedef enum logic [2:0] {
        FU_NONE = 3'd0,
        FU_ALU  = 3'd1,
        FU_SLS  = 3'd2,
        FU_BR   = 3'd3,
        FU_MLS  = 3'd4,
        FU_GEMM = 3'd5
    } fu_e;

    // which unit will produce the pending scalar value
    typedef enum logic [TAG_W-1:0] {
        STAG_NONE = 2'd0,
        STAG_ALU  = 2'd1,
        STAG_JUMP = 2'd2,
        STAG_LOAD = 2'd3
    } stag_e;

    typedef enum logic [TAG_W-1:0] {
        MTAG_NONE = 2'd0,
        MTAG_GEMM = 2'd1,
        MTAG_LOAD = 2'd2
    } mtag_e;

    typedef struct packed {
        opcode_e           op;
        fu_e               unit;
        logic              s_write;
        logic              m_write;
        logic [SREG_W-1:0] s_rd;
        logic [SREG_W-1:0] s_rs1;
        logic [SREG_W-1:0] s_rs2;
        logic [MREG_W-1:0] md;
        logic [MREG_W-1:0] ms1;
        logic [MREG_W-1:0] ms2;
        logic [MREG_W-1:0] ms3;
        stag_e             s_tag;
        mtag_e             m_tag;
    } decoded_t;

    typedef struct packed {
        logic              en;
        logic [SREG_W-1:0] idx;
    } scalar_wb_t;

    typedef struct packed {
        logic              en;
        logic [MREG_W-1:0] idx;
    } matrix_wb_t;

    typedef struct packed {
        logic  waw;
        stag_e t1;
        stag_e t2;
    } scalar_src_t;

    typedef struct packed {
        logic  waw;
        mtag_e g1;
        mtag_e g2;
        mtag_e g3;
    } matrix_src_t;

    typedef struct packed {
        opcode_e           op;
        fu_e               unit;
        logic [SREG_W-1:0] s_rd;
        logic [SREG_W-1:0] s_rs1;
        logic [SREG_W-1:0] s_rs2;
        logic [MREG_W-1:0] md;
        logic [MREG_W-1:0] ms1;
        logic [MREG_W-1:0] ms2;
        logic [MREG_W-1:0] ms3;
        stag_e             t1;
        stag_e             t2;
        mtag_e             g1;
        mtag_e             g2;
        mtag_e             g3;
    } issue_t;

endpackage
